// File: Makefile
TOP = decode_issue_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log || { echo "No pass message in log"; exit 1; }

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: hw/decode_issue_ctrl.sv
//--------------------
// Decode register, fetch and execute handshakes, stall and squash
// Holds one instruction, a new one enters as the old one issues
//--------------------

`default_nettype none
`timescale 1ns/1ps

module decode_issue_ctrl import decode_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                f_val,
  input  logic [XLEN-1:0]     f_inst,
  input  logic [XLEN-1:0]     f_pc,
  input  logic [SEQ_BITS-1:0] f_seq_num,
  output logic                f_rdy,
  output logic [XLEN-1:0]     d_inst,
  output logic [XLEN-1:0]     d_pc,
  output logic [SEQ_BITS-1:0] d_seq_num,
  input  logic                dec_wen,
  input  jump_e               dec_jump,
  input  logic [XLEN-1:0]     dec_imm,
  input  logic [XLEN-1:0]     src0_data,
  input  logic                pending0,
  input  logic                pending1,
  input  logic                alloc_rdy,
  output logic                alloc_en,
  output logic                ex_val,
  input  logic                ex_rdy,
  output logic                squash_val,
  output logic [XLEN-1:0]     squash_target
);

  logic d_val;
  logic stall;
  logic f_xfer;
  logic x_xfer;

  //--------------------
  // Handshakes
  //--------------------

  // Wait on a pending source, or on the free list for a writer
  assign stall  = pending0 | pending1 | (dec_wen & ~alloc_rdy);
  assign ex_val = d_val & ~stall;
  assign x_xfer = ex_val & ex_rdy;
  // Empty slot, or it frees up this cycle
  assign f_rdy  = ~d_val | x_xfer;
  assign f_xfer = f_val & f_rdy;

  // Only an issuing writer pops the free list
  assign alloc_en = x_xfer & dec_wen;

  //--------------------
  // Decode register
  //--------------------

  always_ff @(posedge clk) begin
    if (rst)
      d_val <= 1'b0;
    else if (f_xfer)
      d_val <= 1'b1;
    else if (x_xfer)
      d_val <= 1'b0;
  end

  // Payload only loads on a fetch transfer
  always_ff @(posedge clk) begin
    if (f_xfer) begin
      d_inst    <= f_inst;
      d_pc      <= f_pc;
      d_seq_num <= f_seq_num;
    end
  end

  //--------------------
  // Squash
  //--------------------

  assign squash_val = x_xfer & (dec_jump != jump_none);

  always_comb begin
    case (dec_jump)
      jump_jalr: squash_target = (src0_data + dec_imm) & ~32'd1;
      default:   squash_target = d_pc + dec_imm;
    endcase
  end

  // Valid, source data and jump target hold while execute stalls
  a_ex_stable: assert property (@(posedge clk) disable iff (rst)
    (ex_val && !ex_rdy) |=> (ex_val && $stable(src0_data)
                             && $stable(squash_target)));

endmodule

`default_nettype wire

// File: hw/decode_issue_top.sv
//--------------------
// Decode-and-issue stage top level
// Wires control, decoder, rename table and register file together
//--------------------

`default_nettype none
`timescale 1ns/1ps

module decode_issue_top import decode_pkg::*; #(
  parameter  int NUM_PREGS = 48,
  localparam int preg_bits = $clog2(NUM_PREGS)
) (
  input  logic                 clk,
  input  logic                 rst,
  // Fetch
  input  logic                 f_val,
  input  logic [XLEN-1:0]      f_inst,
  input  logic [XLEN-1:0]      f_pc,
  input  logic [SEQ_BITS-1:0]  f_seq_num,
  output logic                 f_rdy,
  // Execute
  output logic                 ex_val,
  output uop_e                 ex_uop,
  output logic [XLEN-1:0]      ex_pc,
  output logic [XLEN-1:0]      ex_op1,
  output logic [XLEN-1:0]      ex_op2,
  output logic [AREG_BITS-1:0] ex_waddr,
  output logic                 ex_wen,
  output logic [preg_bits-1:0] ex_preg,
  output logic [preg_bits-1:0] ex_ppreg,
  output logic [SEQ_BITS-1:0]  ex_seq_num,
  input  logic                 ex_rdy,
  // Completion and commit strobes
  input  logic                 complete_val,
  input  logic [preg_bits-1:0] complete_preg,
  input  logic [XLEN-1:0]      complete_wdata,
  input  logic                 commit_val,
  input  logic [preg_bits-1:0] commit_ppreg,
  // Squash
  output logic                 squash_val,
  output logic [XLEN-1:0]      squash_target,
  output logic [SEQ_BITS-1:0]  squash_seq_num
);

  logic [XLEN-1:0]      d_inst;
  logic [XLEN-1:0]      d_pc;
  logic [SEQ_BITS-1:0]  d_seq_num;
  logic [AREG_BITS-1:0] dec_raddr0;
  logic [AREG_BITS-1:0] dec_raddr1;
  logic                 dec_op2_imm;
  jump_e                dec_jump;
  logic [XLEN-1:0]      dec_imm;
  logic [preg_bits-1:0] lookup_preg0;
  logic [preg_bits-1:0] lookup_preg1;
  logic                 lookup_pending0;
  logic                 lookup_pending1;
  logic                 alloc_en;
  logic                 alloc_rdy;
  logic [XLEN-1:0]      rdata0;
  logic [XLEN-1:0]      rdata1;

  //--------------------
  // Control
  //--------------------

  decode_issue_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .f_val         (f_val),
    .f_inst        (f_inst),
    .f_pc          (f_pc),
    .f_seq_num     (f_seq_num),
    .f_rdy         (f_rdy),
    .d_inst        (d_inst),
    .d_pc          (d_pc),
    .d_seq_num     (d_seq_num),
    .dec_wen       (ex_wen),
    .dec_jump      (dec_jump),
    .dec_imm       (dec_imm),
    .src0_data     (rdata0),
    .pending0      (lookup_pending0),
    .pending1      (lookup_pending1),
    .alloc_rdy     (alloc_rdy),
    .alloc_en      (alloc_en),
    .ex_val        (ex_val),
    .ex_rdy        (ex_rdy),
    .squash_val    (squash_val),
    .squash_target (squash_target)
  );

  //--------------------
  // Decode and rename
  //--------------------

  inst_decoder u_decoder (
    .inst    (d_inst),
    .uop     (ex_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (ex_waddr),
    .wen     (ex_wen),
    .op2_imm (dec_op2_imm),
    .jump    (dec_jump),
    .imm     (dec_imm)
  );

  rename_table #(
    .NUM_PREGS (NUM_PREGS)
  ) u_rename (
    .clk             (clk),
    .rst             (rst),
    .lookup_areg0    (dec_raddr0),
    .lookup_areg1    (dec_raddr1),
    .lookup_preg0    (lookup_preg0),
    .lookup_preg1    (lookup_preg1),
    .lookup_pending0 (lookup_pending0),
    .lookup_pending1 (lookup_pending1),
    .alloc_areg      (ex_waddr),
    .alloc_en        (alloc_en),
    .alloc_rdy       (alloc_rdy),
    .alloc_preg      (ex_preg),
    .alloc_ppreg     (ex_ppreg),
    .complete_val    (complete_val),
    .complete_preg   (complete_preg),
    .commit_val      (commit_val),
    .commit_ppreg    (commit_ppreg)
  );

  regfile #(
    .NUM_PREGS (NUM_PREGS)
  ) u_regfile (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (lookup_preg0),
    .raddr1 (lookup_preg1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (complete_val),
    .waddr  (complete_preg),
    .wdata  (complete_wdata)
  );

  //--------------------
  // Execute payload
  //--------------------

  assign ex_pc          = d_pc;
  assign ex_seq_num     = d_seq_num;
  assign squash_seq_num = d_seq_num;
  assign ex_op1         = rdata0;
  // Immediate replaces source 2 for ADDI and jumps
  assign ex_op2         = dec_op2_imm ? dec_imm : rdata1;

endmodule

`default_nettype wire

// File: hw/decode_pkg.sv
//--------------------
// Shared types and widths for the decode-and-issue stage
// Import with a wildcard in the module header where needed
//--------------------

`default_nettype none

package decode_pkg;

  //--------------------
  // Widths
  //--------------------

  // Data and pc width
  localparam int XLEN = 32;
  // Architectural register address
  localparam int AREG_BITS = 5;
  // Sequence number from fetch
  localparam int SEQ_BITS = 8;

  //--------------------
  // Enums
  //--------------------

  // Micro-ops sent to the execute pipe
  typedef enum logic [2:0] {
    uop_add,
    uop_sub,
    uop_addi,
    uop_jal,
    uop_jalr
  } uop_e;

  // Immediate formats in the supported subset
  typedef enum logic [0:0] {
    imm_i,
    imm_j
  } imm_type_e;

  // Jump kind, drives squash generation
  typedef enum logic [1:0] {
    jump_none,
    jump_jal,
    jump_jalr
  } jump_e;

endpackage

`default_nettype wire

// File: hw/inst_decoder.sv
//--------------------
// Combinational decoder for ADD, SUB, ADDI, JAL and JALR
// Produces micro-op, register fields and sign-extended immediate
//--------------------

`default_nettype none
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
  input  logic [XLEN-1:0]      inst,
  output uop_e                 uop,
  output logic [AREG_BITS-1:0] raddr0,
  output logic [AREG_BITS-1:0] raddr1,
  output logic [AREG_BITS-1:0] waddr,
  output logic                 wen,
  output logic                 op2_imm,
  output jump_e                jump,
  output logic [XLEN-1:0]      imm
);

  // Major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;

  imm_type_e imm_sel;
  logic      is_sub;

  // SUB has funct7 0100000 with funct3 000
  assign is_sub = (inst[31:25] == 7'b0100000) && (inst[14:12] == 3'b000);

  always_comb begin
    // Defaults behave like ADD with no sources
    uop     = uop_add;
    raddr0  = '0;
    raddr1  = '0;
    op2_imm = 1'b0;
    jump    = jump_none;
    imm_sel = imm_i;
    case (inst[6:0])
      opc_op: begin
        uop    = is_sub ? uop_sub : uop_add;
        raddr0 = inst[19:15];
        raddr1 = inst[24:20];
      end
      opc_op_imm: begin
        uop     = uop_addi;
        raddr0  = inst[19:15];
        op2_imm = 1'b1;
      end
      // JAL reads no register
      opc_jal: begin
        uop     = uop_jal;
        op2_imm = 1'b1;
        jump    = jump_jal;
        imm_sel = imm_j;
      end
      opc_jalr: begin
        uop     = uop_jalr;
        raddr0  = inst[19:15];
        op2_imm = 1'b1;
        jump    = jump_jalr;
      end
      default: ;
    endcase
  end

  // Every supported op writes rd, but x0 is discarded
  assign waddr = inst[11:7];
  assign wen   = (waddr != '0);

  // I-type vs J-type immediate
  always_comb begin
    if (imm_sel == imm_j)
      imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    else
      imm = {{20{inst[31]}}, inst[31:20]};
  end

endmodule

`default_nettype wire

// File: hw/regfile.sv
//--------------------
// Physical register file, two combinational reads
// One write port fed by completion, visible the next cycle
//--------------------

`default_nettype none
`timescale 1ns/1ps

module regfile import decode_pkg::*; #(
  parameter  int NUM_PREGS = 48,
  localparam int preg_bits = $clog2(NUM_PREGS)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [preg_bits-1:0] raddr0,
  input  logic [preg_bits-1:0] raddr1,
  output logic [XLEN-1:0]      rdata0,
  output logic [XLEN-1:0]      rdata1,
  input  logic                 wen,
  input  logic [preg_bits-1:0] waddr,
  input  logic [XLEN-1:0]      wdata
);

  logic [XLEN-1:0] regs [NUM_PREGS];

  // No write-to-read bypass
  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

  always_ff @(posedge clk) begin
    if (rst) begin
      // Architectural state starts at zero
      for (int i = 0; i < NUM_PREGS; i++)
        regs[i] <= '0;
    end else if (wen && (waddr != '0)) begin
      // preg 0 backs x0 and stays zero
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: hw/rename_table.sv
//--------------------
// Rename table with pending bits and a circular free list
// Lookups and alloc head are combinational, updates land at the edge
//--------------------

`default_nettype none
`timescale 1ns/1ps

module rename_table import decode_pkg::*; #(
  parameter  int NUM_PREGS = 48,
  localparam int preg_bits = $clog2(NUM_PREGS)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [AREG_BITS-1:0] lookup_areg0,
  input  logic [AREG_BITS-1:0] lookup_areg1,
  output logic [preg_bits-1:0] lookup_preg0,
  output logic [preg_bits-1:0] lookup_preg1,
  output logic                 lookup_pending0,
  output logic                 lookup_pending1,
  input  logic [AREG_BITS-1:0] alloc_areg,
  input  logic                 alloc_en,
  output logic                 alloc_rdy,
  output logic [preg_bits-1:0] alloc_preg,
  output logic [preg_bits-1:0] alloc_ppreg,
  input  logic                 complete_val,
  input  logic [preg_bits-1:0] complete_preg,
  input  logic                 commit_val,
  input  logic [preg_bits-1:0] commit_ppreg
);

  localparam int num_aregs = 2 ** AREG_BITS;
  // Registers beyond the identity mapping
  localparam int fl_depth  = NUM_PREGS - num_aregs;
  localparam int fl_bits   = $clog2(fl_depth);
  localparam int cnt_bits  = $clog2(fl_depth + 1);

  logic [preg_bits-1:0] map_table [num_aregs];
  logic [NUM_PREGS-1:0] pending;
  logic [preg_bits-1:0] free_list [fl_depth];
  logic [fl_bits-1:0]   fl_head;
  logic [fl_bits-1:0]   fl_tail;
  logic [cnt_bits-1:0]  fl_count;

  //--------------------
  // Lookup and allocation head
  //--------------------

  assign lookup_preg0    = map_table[lookup_areg0];
  assign lookup_preg1    = map_table[lookup_areg1];
  // x0 maps to preg 0 which never goes pending
  assign lookup_pending0 = pending[lookup_preg0];
  assign lookup_pending1 = pending[lookup_preg1];

  assign alloc_rdy   = (fl_count != '0);
  assign alloc_preg  = free_list[fl_head];
  assign alloc_ppreg = map_table[alloc_areg];

  //--------------------
  // State update
  //--------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map, list holds 32 and up in order
      for (int i = 0; i < num_aregs; i++)
        map_table[i] <= preg_bits'(i);
      for (int i = 0; i < fl_depth; i++)
        free_list[i] <= preg_bits'(num_aregs + i);
      pending  <= '0;
      fl_head  <= '0;
      fl_tail  <= '0;
      fl_count <= cnt_bits'(fl_depth);
    end else begin
      // Clear before set, the two never hit the same preg
      if (complete_val)
        pending[complete_preg] <= 1'b0;
      if (alloc_en) begin
        map_table[alloc_areg]         <= free_list[fl_head];
        pending[free_list[fl_head]]   <= 1'b1;
        fl_head <= (fl_head == fl_bits'(fl_depth - 1)) ? '0 : fl_head + 1'b1;
      end
      // Commit returns the old mapping at the tail
      if (commit_val) begin
        free_list[fl_tail] <= commit_ppreg;
        fl_tail <= (fl_tail == fl_bits'(fl_depth - 1)) ? '0 : fl_tail + 1'b1;
      end
      fl_count <= fl_count + cnt_bits'(commit_val) - cnt_bits'(alloc_en);
    end
  end

  //--------------------
  // Checks
  //--------------------

  // Control must see alloc_rdy before allocating
  a_no_alloc_empty: assert property (@(posedge clk) disable iff (rst)
    alloc_en |-> alloc_rdy);

  // Commit never returns more than the list can hold
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    (commit_val && !alloc_en) |-> (fl_count != cnt_bits'(fl_depth)));

  // Completion only for an in-flight register
  a_complete_pending: assert property (@(posedge clk) disable iff (rst)
    complete_val |-> pending[complete_preg]);

endmodule

`default_nettype wire

// File: sim.f
+incdir+verif
hw/decode_pkg.sv
hw/inst_decoder.sv
hw/rename_table.sv
hw/regfile.sv
hw/decode_issue_ctrl.sv
hw/decode_issue_top.sv
verif/decode_issue_tb.sv

// File: verif/decode_issue_model.svh
//--------------------
// Reference model for the decode-and-issue testbench
// Included inside the testbench module after its localparams
//--------------------

`ifndef DECODE_ISSUE_MODEL_SVH
`define DECODE_ISSUE_MODEL_SVH

// One fetched instruction as the testbench built it
typedef struct packed {
  uop_e                 uop;
  logic [AREG_BITS-1:0] rd;
  logic [AREG_BITS-1:0] rs1;
  logic [AREG_BITS-1:0] rs2;
  logic [XLEN-1:0]      imm;
  logic [XLEN-1:0]      pc;
  logic [SEQ_BITS-1:0]  seq;
} inst_rec_t;

// Issued writer waiting for completion, then commit
typedef struct packed {
  logic [preg_bits-1:0] preg;
  logic [preg_bits-1:0] ppreg;
  logic [XLEN-1:0]      data;
  logic [31:0]          due;
} writer_rec_t;

// Architectural values, updated in issue order
logic [XLEN-1:0]      arch_val [32];
// Rename map and free list as the stage should hold them
logic [preg_bits-1:0] arch_map [32];
logic [preg_bits-1:0] free_q [$];

task automatic reset_model();
  free_q.delete();
  for (int i = 0; i < 32; i++) begin
    arch_val[i] = '0;
    arch_map[i] = preg_bits'(i);
  end
  // Pregs above the identity map, ascending
  for (int i = 32; i < num_pregs; i++)
    free_q.push_back(preg_bits'(i));
endtask

// x0 always reads zero
function automatic logic [XLEN-1:0] src_value(logic [AREG_BITS-1:0] areg);
  return (areg == '0) ? '0 : arch_val[areg];
endfunction

// Source 2 for R-type, immediate otherwise
function automatic logic [XLEN-1:0] expected_op2(inst_rec_t rec);
  if (rec.uop == uop_add || rec.uop == uop_sub)
    return src_value(rec.rs2);
  return rec.imm;
endfunction

// Value written to rd, jumps link pc plus 4
function automatic logic [XLEN-1:0] expected_result(inst_rec_t rec);
  case (rec.uop)
    uop_add:  return src_value(rec.rs1) + src_value(rec.rs2);
    uop_sub:  return src_value(rec.rs1) - src_value(rec.rs2);
    uop_addi: return src_value(rec.rs1) + rec.imm;
    default:  return rec.pc + 32'd4;
  endcase
endfunction

// JALR clears bit 0 of the sum
function automatic logic [XLEN-1:0] expected_target(inst_rec_t rec);
  if (rec.uop == uop_jalr)
    return (src_value(rec.rs1) + rec.imm) & ~32'd1;
  return rec.pc + rec.imm;
endfunction

`endif

// File: verif/decode_issue_tb.sv
//--------------------
// Testbench for the decode-and-issue stage
// Plays fetch, execute, completion and commit with random timing
// Checks every execute transfer against the reference model
//--------------------

`default_nettype none
`timescale 1ns/1ps

module decode_issue_tb import decode_pkg::*; ();

  localparam int num_pregs       = 48;
  localparam int preg_bits       = $clog2(num_pregs);
  localparam int clk_period      = 20;
  localparam int n_alu           = 300;
  localparam int n_fl            = 40;
  localparam int n_jmp           = 100;
  localparam int watchdog_cycles = (n_alu + n_fl + n_jmp) * 40;

  `include "decode_issue_model.svh"

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 f_val;
  logic [XLEN-1:0]      f_inst;
  logic [XLEN-1:0]      f_pc;
  logic [SEQ_BITS-1:0]  f_seq_num;
  logic                 f_rdy;
  logic                 ex_val;
  uop_e                 ex_uop;
  logic [XLEN-1:0]      ex_pc;
  logic [XLEN-1:0]      ex_op1;
  logic [XLEN-1:0]      ex_op2;
  logic [AREG_BITS-1:0] ex_waddr;
  logic                 ex_wen;
  logic [preg_bits-1:0] ex_preg;
  logic [preg_bits-1:0] ex_ppreg;
  logic [SEQ_BITS-1:0]  ex_seq_num;
  logic                 ex_rdy;
  logic                 complete_val;
  logic [preg_bits-1:0] complete_preg;
  logic [XLEN-1:0]      complete_wdata;
  logic                 commit_val;
  logic [preg_bits-1:0] commit_ppreg;
  logic                 squash_val;
  logic [XLEN-1:0]      squash_target;
  logic [SEQ_BITS-1:0]  squash_seq_num;

  // Run state
  integer              seed;
  int                  cycle;
  int                  error_count;
  int                  tests_failed;
  int                  test_fetched;
  int                  test_issued;
  int                  stall_cycles;
  int                  last_due;
  logic                commit_hold;
  logic                jump_wait;
  logic                fetch_taken;
  logic [XLEN-1:0]     next_pc;
  logic [SEQ_BITS-1:0] next_seq;
  inst_rec_t           cur_rec;
  inst_rec_t           stage_q [$];
  writer_rec_t         complete_q [$];
  writer_rec_t         commit_q [$];

  // Execute outputs from the previous cycle
  logic                 hold_last;
  uop_e                 held_uop;
  logic [XLEN-1:0]      held_pc;
  logic [XLEN-1:0]      held_op1;
  logic [XLEN-1:0]      held_op2;
  logic [AREG_BITS-1:0] held_waddr;
  logic                 held_wen;
  logic [preg_bits-1:0] held_preg;
  logic [preg_bits-1:0] held_ppreg;
  logic [SEQ_BITS-1:0]  held_seq;

  decode_issue_top #(
    .NUM_PREGS (num_pregs)
  ) u_dut (
    .clk            (clk),
    .rst            (rst),
    .f_val          (f_val),
    .f_inst         (f_inst),
    .f_pc           (f_pc),
    .f_seq_num      (f_seq_num),
    .f_rdy          (f_rdy),
    .ex_val         (ex_val),
    .ex_uop         (ex_uop),
    .ex_pc          (ex_pc),
    .ex_op1         (ex_op1),
    .ex_op2         (ex_op2),
    .ex_waddr       (ex_waddr),
    .ex_wen         (ex_wen),
    .ex_preg        (ex_preg),
    .ex_ppreg       (ex_ppreg),
    .ex_seq_num     (ex_seq_num),
    .ex_rdy         (ex_rdy),
    .complete_val   (complete_val),
    .complete_preg  (complete_preg),
    .complete_wdata (complete_wdata),
    .commit_val     (commit_val),
    .commit_ppreg   (commit_ppreg),
    .squash_val     (squash_val),
    .squash_target  (squash_target),
    .squash_seq_num (squash_seq_num)
  );

  always #(clk_period / 2) clk = ~clk;

  //--------------------
  // Helpers
  //--------------------

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH %s got %h expected %h at cycle %0d", name, got, exp, cycle);
    error_count++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at cycle %0d: %s", cycle, msg);
    error_count++;
  endtask

  // RV32I encodings for the supported subset
  function automatic logic [31:0] encode_inst(inst_rec_t rec);
    case (rec.uop)
      uop_add:  return {7'b0000000, rec.rs2, rec.rs1, 3'b000, rec.rd, 7'b0110011};
      uop_sub:  return {7'b0100000, rec.rs2, rec.rs1, 3'b000, rec.rd, 7'b0110011};
      uop_addi: return {rec.imm[11:0], rec.rs1, 3'b000, rec.rd, 7'b0010011};
      uop_jalr: return {rec.imm[11:0], rec.rs1, 3'b000, rec.rd, 7'b1100111};
      default:  return {rec.imm[20], rec.imm[10:1], rec.imm[11], rec.imm[19:12],
                        rec.rd, 7'b1101111};
    endcase
  endfunction

  // Mode 0 ALU mix, 1 writers only, 2 ALU mix with jumps
  task automatic gen_inst(input int mode, output inst_rec_t rec);
    logic [31:0] r;
    int          pick;
    r       = $random(seed);
    pick    = rand_below(8);
    rec.rd  = 5'(rand_below(8));
    rec.rs1 = 5'(rand_below(8));
    rec.rs2 = 5'(rand_below(8));
    rec.imm = {{20{r[11]}}, r[11:0]};
    rec.pc  = next_pc;
    rec.seq = next_seq;
    if (pick < 3)
      rec.uop = uop_add;
    else if (pick < 5)
      rec.uop = uop_sub;
    else
      rec.uop = uop_addi;
    if (mode == 1) begin
      rec.uop = uop_addi;
      rec.rd  = 5'(1 + rand_below(7));
    end else if (mode == 2 && pick < 2) begin
      rec.uop = uop_jal;
      rec.imm = {{11{r[20]}}, r[20:1], 1'b0};
    end else if (mode == 2 && pick == 2) begin
      rec.uop = uop_jalr;
    end
  endtask

  //--------------------
  // Falling-edge drive
  //--------------------

  task automatic drive_inputs(input int mode, input int num);
    writer_rec_t w;
    if (fetch_taken) begin
      f_val       = 1'b0;
      fetch_taken = 1'b0;
    end
    // Random gaps, and no fetch past an unissued jump
    if (!f_val && !jump_wait && test_fetched < num && rand_below(4) != 0) begin
      gen_inst(mode, cur_rec);
      f_val     = 1'b1;
      f_inst    = encode_inst(cur_rec);
      f_pc      = cur_rec.pc;
      f_seq_num = cur_rec.seq;
    end
    ex_rdy = (rand_below(4) != 0);
    if (commit_hold && free_q.size() == 0 && stall_cycles >= 8)
      commit_hold = 1'b0;
    complete_val = 1'b0;
    if (complete_q.size() != 0 && complete_q[0].due <= 32'(cycle)) begin
      w              = complete_q.pop_front();
      complete_val   = 1'b1;
      complete_preg  = w.preg;
      complete_wdata = w.data;
      // Commit 1 to 3 cycles after completion
      w.due          = 32'(cycle + 1 + rand_below(3));
      commit_q.push_back(w);
    end
    commit_val = 1'b0;
    if (!commit_hold && commit_q.size() != 0 && commit_q[0].due <= 32'(cycle)) begin
      w            = commit_q.pop_front();
      commit_val   = 1'b1;
      commit_ppreg = w.ppreg;
    end
  endtask

  //--------------------
  // Checks, one settle step after the drive
  //--------------------

  task automatic check_issue();
    inst_rec_t       rec;
    writer_rec_t     w;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] target;
    logic            is_jump;
    int              due_cycle;
    rec     = stage_q.pop_front();
    is_jump = (rec.uop == uop_jal) || (rec.uop == uop_jalr);
    if (ex_seq_num !== rec.seq)
      report_mismatch("ex_seq_num", 32'(ex_seq_num), 32'(rec.seq));
    if (ex_pc !== rec.pc)
      report_mismatch("ex_pc", ex_pc, rec.pc);
    if (ex_uop !== rec.uop)
      report_mismatch("ex_uop", 32'(ex_uop), 32'(rec.uop));
    if (ex_waddr !== rec.rd)
      report_mismatch("ex_waddr", 32'(ex_waddr), 32'(rec.rd));
    if (ex_wen !== (rec.rd != '0))
      report_mismatch("ex_wen", 32'(ex_wen), 32'(rec.rd != '0));
    if (squash_val !== is_jump)
      report_mismatch("squash_val", 32'(squash_val), 32'(is_jump));
    if (is_jump) begin
      target = expected_target(rec);
      if (squash_target !== target)
        report_mismatch("squash_target", squash_target, target);
      if (squash_seq_num !== rec.seq)
        report_mismatch("squash_seq_num", 32'(squash_seq_num), 32'(rec.seq));
      // Fetch restarts at the target
      next_pc   = target;
      jump_wait = 1'b0;
    end else begin
      if (ex_op1 !== src_value(rec.rs1))
        report_mismatch("ex_op1", ex_op1, src_value(rec.rs1));
      if (ex_op2 !== expected_op2(rec))
        report_mismatch("ex_op2", ex_op2, expected_op2(rec));
    end
    result = expected_result(rec);
    if (rec.rd != '0) begin
      if (free_q.size() == 0) begin
        report_error("a writer issued while the free list was empty");
      end else begin
        if (ex_preg !== free_q[0])
          report_mismatch("ex_preg", 32'(ex_preg), 32'(free_q[0]));
        if (ex_ppreg !== arch_map[rec.rd])
          report_mismatch("ex_ppreg", 32'(ex_ppreg), 32'(arch_map[rec.rd]));
        // Completion 1 to 4 cycles out, kept in order
        due_cycle = cycle + 1 + rand_below(4);
        if (due_cycle <= last_due)
          due_cycle = last_due + 1;
        last_due = due_cycle;
        w.preg   = free_q.pop_front();
        w.ppreg  = arch_map[rec.rd];
        w.data   = result;
        w.due    = 32'(due_cycle);
        complete_q.push_back(w);
        arch_map[rec.rd] = w.preg;
      end
      arch_val[rec.rd] = result;
    end
    test_issued++;
  endtask

  task automatic check_cycle();
    logic x_xfer;
    logic exp_f_rdy;
    x_xfer    = ex_val && ex_rdy;
    exp_f_rdy = (stage_q.size() == 0) || x_xfer;
    // Full slot under back-pressure keeps fetch out
    if (f_rdy !== exp_f_rdy)
      report_mismatch("f_rdy", 32'(f_rdy), 32'(exp_f_rdy));
    if (ex_val && stage_q.size() == 0)
      report_error("ex_val is high with no instruction in the stage");
    if (hold_last) begin
      if (ex_val !== 1'b1)
        report_error("ex_val dropped while execute was stalled");
      if (ex_uop !== held_uop)
        report_mismatch("ex_uop", 32'(ex_uop), 32'(held_uop));
      if (ex_pc !== held_pc)
        report_mismatch("ex_pc", ex_pc, held_pc);
      if (ex_op1 !== held_op1)
        report_mismatch("ex_op1", ex_op1, held_op1);
      if (ex_op2 !== held_op2)
        report_mismatch("ex_op2", ex_op2, held_op2);
      if (ex_waddr !== held_waddr)
        report_mismatch("ex_waddr", 32'(ex_waddr), 32'(held_waddr));
      if (ex_wen !== held_wen)
        report_mismatch("ex_wen", 32'(ex_wen), 32'(held_wen));
      if (ex_preg !== held_preg)
        report_mismatch("ex_preg", 32'(ex_preg), 32'(held_preg));
      if (ex_ppreg !== held_ppreg)
        report_mismatch("ex_ppreg", 32'(ex_ppreg), 32'(held_ppreg));
      if (ex_seq_num !== held_seq)
        report_mismatch("ex_seq_num", 32'(ex_seq_num), 32'(held_seq));
    end
    // Writer waiting on an empty free list
    if (stage_q.size() != 0 && stage_q[0].rd != '0 && free_q.size() == 0) begin
      if (ex_val)
        report_error("a writer was offered to execute with the free list empty");
      else
        stall_cycles++;
    end
    if (x_xfer && stage_q.size() != 0)
      check_issue();
    else if (squash_val !== 1'b0)
      report_mismatch("squash_val", 32'(squash_val), 32'(0));
    if (f_val && f_rdy) begin
      stage_q.push_back(cur_rec);
      fetch_taken = 1'b1;
      test_fetched++;
      next_seq = next_seq + 1'b1;
      if (cur_rec.uop == uop_jal || cur_rec.uop == uop_jalr)
        jump_wait = 1'b1;
      else
        next_pc = cur_rec.pc + 32'd4;
    end
    // Commit lands at the tail on this edge
    if (commit_val)
      free_q.push_back(commit_ppreg);
    hold_last  = ex_val && !ex_rdy;
    held_uop   = ex_uop;
    held_pc    = ex_pc;
    held_op1   = ex_op1;
    held_op2   = ex_op2;
    held_waddr = ex_waddr;
    held_wen   = ex_wen;
    held_preg  = ex_preg;
    held_ppreg = ex_ppreg;
    held_seq   = ex_seq_num;
  endtask

  task automatic run_test(input string name, input int num, input int mode);
    int errs_before;
    errs_before  = error_count;
    test_fetched = 0;
    test_issued  = 0;
    stall_cycles = 0;
    // Free-list test withholds commits until the list runs dry
    commit_hold  = (mode == 1);
    while (test_issued < num) begin
      @(negedge clk);
      cycle++;
      drive_inputs(mode, num);
      #1;
      check_cycle();
    end
    if (mode == 1 && stall_cycles == 0)
      report_error("the free list never ran empty during the back-pressure test");
    if (error_count != errs_before)
      tests_failed++;
    $display("test %-10s %s  issued %0d  errors %0d", name,
             (error_count == errs_before) ? "pass" : "fail", test_issued,
             error_count - errs_before);
  endtask

  //--------------------
  // Main sequence
  //--------------------

  initial begin
    seed           = 7265;
    rst            = 1'b1;
    f_val          = 1'b0;
    f_inst         = '0;
    f_pc           = '0;
    f_seq_num      = '0;
    ex_rdy         = 1'b0;
    complete_val   = 1'b0;
    complete_preg  = '0;
    complete_wdata = '0;
    commit_val     = 1'b0;
    commit_ppreg   = '0;
    cycle          = 0;
    error_count    = 0;
    tests_failed   = 0;
    last_due       = 0;
    commit_hold    = 1'b0;
    jump_wait      = 1'b0;
    fetch_taken    = 1'b0;
    hold_last      = 1'b0;
    next_pc        = 32'h0000_1000;
    next_seq       = '0;
    reset_model();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    // Idle state straight out of reset
    if (ex_val !== 1'b0 || squash_val !== 1'b0 || f_rdy !== 1'b1)
      report_error("outputs not idle after reset");
    run_test("operands", n_alu, 0);
    run_test("free_list", n_fl, 1);
    run_test("jumps", n_jmp, 2);
    $display("Summary: 3 tests, %0d failed, %0d errors", tests_failed, error_count);
    if (error_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // Bound on total run length
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
